// File: verilog/rng_settings.svh
// word width, burst length and xorshift amounts for the burst generator, included by package and testbench
`ifndef RNG_SETTINGS_SVH
`define RNG_SETTINGS_SVH

// generator word width in bits
`define RNG_WIDTH 32

// words emitted per accepted seed
`define RNG_BURST_LEN 256

// xorshift32 triple, applied in order
`define RNG_SHIFT_A 13 // left
`define RNG_SHIFT_B 17 // right
`define RNG_SHIFT_C 5  // left

// counter width, enough to index every word of a burst
`define RNG_CNT_WIDTH $clog2(`RNG_BURST_LEN)

`endif

// File: verilog/rng_pkg.sv
// shared types of the burst generator, imported by every design module that needs them
`include "rng_settings.svh"

package rng_pkg;

    // one generator word
    typedef logic [`RNG_WIDTH-1:0] rng_word_t;

    // position inside a burst, 0 .. RNG_BURST_LEN-1
    typedef logic [`RNG_CNT_WIDTH-1:0] burst_cnt_t;

    // burst controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // waiting for a seed
        RUN   = 2'd1, // one word per cycle while hold is low
        PAUSE = 2'd2  // held off by downstream
    } rng_state_e;

    // pulses from the controller to counter and core
    typedef struct packed {
        logic load; // capture the seed
        logic step; // advance and emit one word
    } rng_ctrl_t;

    // registered output word
    typedef struct packed {
        logic      valid; // one cycle per word
        rng_word_t num;   // zero when valid is low
    } rng_out_t;

endpackage

// File: verilog/rng_ctrl_fsm.sv
// burst controller FSM, turns in_valid, hold and last into load/step pulses and the busy level
module rng_ctrl_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid, // seed strobe, only honoured when idle
    input  logic              hold,     // downstream back-pressure level
    input  logic              last,     // counter sits on the final word
    output rng_pkg::rng_ctrl_t ctrl,
    output logic              busy
);

    import rng_pkg::*;

    rng_state_e state;
    rng_state_e state_nxt;
    logic       load;
    logic       step;

    // strobes are pure decodes of the current state and inputs
    assign load = (state == IDLE) && in_valid;
    assign step = (state == RUN) && !hold;

    always_comb begin
        ctrl      = '0;
        ctrl.load = load;
        ctrl.step = step;
    end

    assign busy = (state != IDLE);

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (hold) begin
                    state_nxt = PAUSE; // no step this edge
                end else if (last) begin
                    state_nxt = IDLE;  // final step of the burst
                end
            end
            PAUSE: begin
                // resume without a step, next word one edge later
                if (!hold) begin
                    state_nxt = RUN;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: verilog/burst_counter.sv
// word counter of one burst, cleared by load, advanced by step, flags the final word
`include "rng_settings.svh"

module burst_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  rng_pkg::rng_ctrl_t ctrl,
    output logic               last
);

    import rng_pkg::*;

    localparam burst_cnt_t LAST_IDX = burst_cnt_t'(`RNG_BURST_LEN - 1);

    burst_cnt_t cnt;

    // index of the word the next step will produce
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (ctrl.load) begin
            cnt <= '0; // fresh burst
        end else if (ctrl.step) begin
            cnt <= cnt + 1'b1; // wraps to zero after the last word
        end
    end

    // position only, the controller decides when a step happens
    assign last = (cnt == LAST_IDX);

endmodule

// File: verilog/xorshift_core.sv
// xorshift32 generator state and registered output stage of the burst generator
`include "rng_settings.svh"

module xorshift_core (
    input  logic               clk,
    input  logic               rst_n,
    input  rng_pkg::rng_word_t seed,
    input  rng_pkg::rng_ctrl_t ctrl,
    output rng_pkg::rng_out_t  rng_out
);

    import rng_pkg::*;

    rng_word_t gen_state;
    rng_word_t next_word;

    // one xorshift32 round, the three shifts applied in order
    function automatic rng_word_t xorshift_next(input rng_word_t x);
        rng_word_t t;
        t = x ^ (x << `RNG_SHIFT_A);
        t = t ^ (t >> `RNG_SHIFT_B);
        t = t ^ (t << `RNG_SHIFT_C);
        return t;
    endfunction

    assign next_word = xorshift_next(gen_state);

    // generator state, seeded by load and advanced by step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gen_state <= '0;
        end else if (ctrl.load) begin
            gen_state <= seed;
        end else if (ctrl.step) begin
            gen_state <= next_word;
        end
    end

    // output word lands one cycle after its step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rng_out <= '0;
        end else if (ctrl.step) begin
            rng_out.valid <= 1'b1;
            rng_out.num   <= next_word; // same value the state takes
        end else begin
            rng_out <= '0; // num is zero between words
        end
    end

endmodule

// File: verilog/rng_burst_top.sv
// top level of the burst generator, connects controller, counter and xorshift core
module rng_burst_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid, // one-cycle seed strobe
    input  rng_pkg::rng_word_t seed,
    input  logic               hold,     // pauses the burst while high
    output rng_pkg::rng_out_t  rng_out,
    output logic               busy      // high for the whole burst
);

    import rng_pkg::*;

    rng_ctrl_t ctrl; // load/step from the controller
    logic      last; // final word of the burst

    // burst FSM
    rng_ctrl_fsm u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .hold     (hold),
        .last     (last),
        .ctrl     (ctrl),
        .busy     (busy)
    );

    // position within the burst
    burst_counter u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl),
        .last  (last)
    );

    // generator and output register
    xorshift_core u_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .seed    (seed),
        .ctrl    (ctrl),
        .rng_out (rng_out)
    );

endmodule

// File: testbench/rng_burst_assert.sv
// concurrent checks with an independent xorshift model, bound into rng_burst_top by the bind below
`include "rng_settings.svh"

module rng_burst_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               in_valid,
    input rng_pkg::rng_word_t seed,
    input logic               hold,
    input rng_pkg::rng_out_t  rng_out,
    input logic               busy
);

    timeunit 1ns;
    timeprecision 1ps;

    import rng_pkg::*;

    localparam int LEN = `RNG_BURST_LEN;

    logic                    seen_seed;   // first in_valid has been seen
    logic                    accept;      // seed taken this edge
    rng_word_t               model;       // last word of the reference sequence
    rng_word_t               expected;    // word the DUT must emit next
    logic [`RNG_CNT_WIDTH:0] word_cnt;    // words seen in the current burst
    int unsigned             bursts_done;
    int unsigned             fail_cnt = 0;

    // reference xorshift32 step, shifts taken straight from the settings header
    function automatic rng_word_t successor(input rng_word_t x);
        rng_word_t a;
        rng_word_t b;
        rng_word_t c;
        a = x ^ (x << `RNG_SHIFT_A);
        b = a ^ (a >> `RNG_SHIFT_B);
        c = b ^ (b << `RNG_SHIFT_C);
        return c;
    endfunction

    assign accept   = in_valid && !busy; // strobes during a burst are ignored
    assign expected = successor(model);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_seed   <= 1'b0;
            model       <= '0;
            word_cnt    <= '0;
            bursts_done <= 0;
        end else begin
            if (in_valid) begin
                seen_seed <= 1'b1;
            end
            if (accept) begin
                model    <= seed;
                word_cnt <= '0;
            end else if (rng_out.valid) begin
                model    <= expected;
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == LEN - 1) begin
                    bursts_done <= bursts_done + 1; // burst complete
                end
            end
        end
    end

    // quiet until the first seed
    a_quiet_before_seed: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_seed |-> !busy && !rng_out.valid)
        else begin
            fail_cnt++;
            $error("busy or rng_out.valid went high before any seed was given");
        end

    // every word follows the model sequence
    a_word_value: assert property (@(posedge clk) disable iff (!rst_n)
        rng_out.valid |-> rng_out.num == expected)
        else begin
            fail_cnt++;
            $error("[FAIL] %0t rng_out.num: got %h, expected %h",
                   $time, $sampled(rng_out.num), $sampled(expected));
        end

    // a held edge never produces a word
    a_hold_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> !rng_out.valid)
        else begin
            fail_cnt++;
            $error("[FAIL] %0t rng_out.valid: got 1, expected 0 after hold was high", $time);
        end

    a_no_extra_word: assert property (@(posedge clk) disable iff (!rst_n)
        rng_out.valid |-> word_cnt < LEN)
        else begin
            fail_cnt++;
            $error("a burst delivered more words than the burst length");
        end

    // busy drops together with the last word, never earlier or later
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> rng_out.valid && word_cnt == LEN - 1)
        else begin
            fail_cnt++;
            $error("busy fell before the last word of the burst arrived");
        end

    a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        rng_out.valid && word_cnt == LEN - 1 |-> !busy)
        else begin
            fail_cnt++;
            $error("busy stayed high after the last word of the burst");
        end

    a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> busy)
        else begin
            fail_cnt++;
            $error("busy did not rise one cycle after a seed was accepted");
        end

endmodule

bind rng_burst_top rng_burst_assert u_chk (.*);

// File: testbench/rng_burst_tb.sv
// testbench for the burst generator, two seeded bursts with random back-pressure, bound checker judges
`include "rng_settings.svh"

module rng_burst_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rng_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          BUSY_TIMEOUT = 8 * `RNG_BURST_LEN; // cycles, room for random hold
    localparam int          STRAY_CYCLE  = 40;                 // ignored strobe inside burst one
    localparam logic [31:0] SEED_INIT    = 32'hb968ba50;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    rng_word_t seed;
    logic      hold;
    rng_out_t  rng_out;
    logic      busy;

    integer    rand_seed;
    rng_word_t seed_first;
    rng_word_t seed_stray;
    rng_word_t seed_second;

    rng_burst_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .seed     (seed),
        .hold     (hold),
        .rng_out  (rng_out),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_seed(input rng_word_t value);
        seed     = value;
        in_valid = 1'b1;
        next_cycle();
        in_valid = 1'b0;
    endtask

    // steps through the burst until busy drops, optionally with random hold and a stray seed
    task automatic run_until_idle(input logic random_hold, input rng_word_t stray);
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles >= BUSY_TIMEOUT) begin
                abort_run("timeout: busy stayed high past the cycle limit");
            end
            if (random_hold) begin
                hold = (($random(rand_seed) & 3) == 0); // roughly one edge in four
            end else begin
                hold = 1'b0;
            end
            if (random_hold && cycles == STRAY_CYCLE) begin
                seed     = stray; // must be ignored, burst is running
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
            next_cycle();
            cycles++;
        end
        hold     = 1'b0;
        in_valid = 1'b0;
    endtask

    // first assertion failure ends the run
    always @(u_dut.u_chk.fail_cnt) begin
        if (u_dut.u_chk.fail_cnt != 0) begin
            abort_run("an assertion in the bound checker failed");
        end
    end

    initial begin
        rand_seed = SEED_INIT;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        seed      = '0;
        hold      = 1'b0;

        seed_first  = $random(rand_seed);
        seed_stray  = $random(rand_seed);
        seed_second = $random(rand_seed);

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle, nothing may come out yet
        repeat (5) next_cycle();

        // burst one with back-pressure
        send_seed(seed_first);
        run_until_idle(1'b1, seed_stray);
        repeat (4) next_cycle();

        // burst two, free running from a new seed
        send_seed(seed_second);
        run_until_idle(1'b0, seed_second);
        repeat (4) next_cycle();

        if (u_dut.u_chk.fail_cnt == 0 && u_dut.u_chk.bursts_done == 2) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("the checker did not see two complete bursts");
        end
    end

endmodule

// File: rng_burst_top.f
+incdir+verilog
verilog/rng_pkg.sv
verilog/rng_ctrl_fsm.sv
verilog/burst_counter.sv
verilog/xorshift_core.sv
verilog/rng_burst_top.sv
testbench/rng_burst_assert.sv
testbench/rng_burst_tb.sv
